//--- design/nvme_cfg_pkg.sv
`default_nettype none

package nvme_cfg_pkg;

    // --------------------------------------------------
    // channel counts
    // --------------------------------------------------
    // front-end side, hosts issuing admin requests
    localparam int FE_CH = 4;
    // back-end side, drives answering with completions
    localparam int BE_CH = 2;

    // channel-number bits carried in the low id bits
    localparam int FE_IDX = $clog2(FE_CH);
    localparam int BE_IDX = $clog2(BE_CH);

    // --------------------------------------------------
    // field widths
    // --------------------------------------------------
    localparam int ID_W   = 12;
    localparam int ADDR_W = 32;
    localparam int HASH_W = 16;

    // --------------------------------------------------
    // queueing
    // --------------------------------------------------
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // shared by ingress (idle/enqueue) and egress (idle/dequeue)
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_ENQUEUE = 2'd1,
        ST_DEQUEUE = 2'd2
    } admin_state_t;

endpackage : nvme_cfg_pkg

`default_nettype wire

//--- design/nvme_msg_pkg.sv
`default_nettype none

package nvme_msg_pkg;

    import nvme_cfg_pkg::*;

    // --------------------------------------------------
    // request opcodes
    // --------------------------------------------------
    typedef enum logic [1:0] {
        RQ_READ  = 2'd0,
        RQ_WRITE = 2'd1,
        RQ_TRIM  = 2'd2
    } rq_op_t;

    // --------------------------------------------------
    // front end to back end, 63 bits
    // --------------------------------------------------
    typedef struct packed {
        logic              valid;
        rq_op_t            op;
        logic [ADDR_W-1:0] addr;
        logic [HASH_W-1:0] hash;
        // low FE_IDX bits hold the source channel once tagged
        logic [ID_W-1:0]   fe_id;
    } rq_msg_t;

    // --------------------------------------------------
    // back end to front end, 57 bits
    // --------------------------------------------------
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        // low FE_IDX bits select the return channel
        logic [ID_W-1:0]   fe_id;
        // source back-end number, zero-extended
        logic [ID_W-1:0]   be_id;
    } cp_msg_t;

endpackage : nvme_msg_pkg

`default_nettype wire

//--- design/admin_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module admin_fifo
    import nvme_cfg_pkg::*;
#(
    parameter type entry_t = logic [7:0]
) (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   wr_en,
    input  entry_t      wr_data,
    input  wire logic   rd_en,
    output entry_t      rd_data,
    output logic        full,
    output logic        empty
);

    // --------------------------------------------------
    // storage and pointers
    // --------------------------------------------------
    entry_t             mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    // one extra bit so a full buffer is distinct from empty
    logic [FIFO_AW:0]   count;

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------------------------------------
    // data path
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        // read data lands one cycle after rd_en and holds until next read
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

    assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign empty = (count == '0);

endmodule : admin_fifo

`default_nettype wire

//--- design/rq_ingress.sv
`timescale 1ns/100ps
`default_nettype none

module rq_ingress
    import nvme_cfg_pkg::*, nvme_msg_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  rq_msg_t    [FE_CH-1:0] fe_rq,
    output logic       [FE_CH-1:0] fe_rq_ready,
    input  wire logic              full,
    output logic                   wr_en,
    output rq_msg_t                wr_data
);

    admin_state_t      state;
    admin_state_t      next_state;
    logic [FE_IDX-1:0] sel;
    logic              any_valid;
    logic              accept;

    // --------------------------------------------------
    // fixed priority, channel 0 wins
    // --------------------------------------------------
    always_comb begin
        sel       = '0;
        any_valid = 1'b0;
        // walk down so the lowest valid index is left in sel
        for (int i = FE_CH-1; i >= 0; i--) begin
            if (fe_rq[i].valid) begin
                sel       = FE_IDX'(i);
                any_valid = 1'b1;
            end
        end
    end

    // only take a request when the fifo has room
    assign accept = (state == ST_IDLE) && !full && any_valid;

    always_comb begin
        fe_rq_ready = '0;
        if (accept) begin
            fe_rq_ready[sel] = 1'b1;
        end
    end

    // --------------------------------------------------
    // idle / enqueue machine
    // --------------------------------------------------
    always_comb begin
        case (state)
            ST_IDLE:    next_state = accept ? ST_ENQUEUE : ST_IDLE;
            ST_ENQUEUE: next_state = ST_IDLE;
            default:    next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // capture winner, source channel goes in the low id bits
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_data       <= fe_rq[sel];
            wr_data.valid <= 1'b1;
            wr_data.fe_id <= {fe_rq[sel].fe_id[ID_W-1:FE_IDX], sel};
        end
    end

    assign wr_en = (state == ST_ENQUEUE);

endmodule : rq_ingress

`default_nettype wire

//--- design/rq_egress.sv
`timescale 1ns/100ps
`default_nettype none

module rq_egress
    import nvme_cfg_pkg::*, nvme_msg_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              empty,
    output logic                   rd_en,
    input  rq_msg_t                rd_data,
    output rq_msg_t    [BE_CH-1:0] be_rq,
    input  wire logic  [BE_CH-1:0] be_rq_ready
);

    admin_state_t      state;
    admin_state_t      next_state;
    logic [BE_IDX-1:0] sel;
    logic              any_ready;

    // --------------------------------------------------
    // pick the lowest ready back end
    // --------------------------------------------------
    always_comb begin
        sel       = '0;
        any_ready = 1'b0;
        for (int i = BE_CH-1; i >= 0; i--) begin
            if (be_rq_ready[i]) begin
                sel       = BE_IDX'(i);
                any_ready = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // idle / dequeue machine
    // --------------------------------------------------
    always_comb begin
        case (state)
            ST_IDLE:    next_state = empty ? ST_IDLE : ST_DEQUEUE;
            // hold the fetched entry until some back end takes it
            ST_DEQUEUE: next_state = any_ready ? ST_IDLE : ST_DEQUEUE;
            default:    next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign rd_en = (state == ST_IDLE) && !empty;

    // only the chosen channel sees the request, the rest stay zero
    always_comb begin
        be_rq = '0;
        if (state == ST_DEQUEUE && any_ready) begin
            be_rq[sel]       = rd_data;
            be_rq[sel].valid = 1'b1;
        end
    end

endmodule : rq_egress

`default_nettype wire

//--- design/cp_ingress.sv
`timescale 1ns/100ps
`default_nettype none

module cp_ingress
    import nvme_cfg_pkg::*, nvme_msg_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  cp_msg_t    [BE_CH-1:0] be_cp,
    output logic       [BE_CH-1:0] be_cp_ready,
    input  wire logic              full,
    output logic                   wr_en,
    output cp_msg_t                wr_data
);

    admin_state_t      state;
    admin_state_t      next_state;
    logic [BE_IDX-1:0] sel;
    logic              any_valid;
    logic              accept;

    // --------------------------------------------------
    // fixed priority over back-end completions
    // --------------------------------------------------
    always_comb begin
        sel       = '0;
        any_valid = 1'b0;
        for (int i = BE_CH-1; i >= 0; i--) begin
            if (be_cp[i].valid) begin
                sel       = BE_IDX'(i);
                any_valid = 1'b1;
            end
        end
    end

    assign accept = (state == ST_IDLE) && !full && any_valid;

    always_comb begin
        be_cp_ready = '0;
        if (accept) begin
            be_cp_ready[sel] = 1'b1;
        end
    end

    // --------------------------------------------------
    // idle / enqueue machine
    // --------------------------------------------------
    always_comb begin
        case (state)
            ST_IDLE:    next_state = accept ? ST_ENQUEUE : ST_IDLE;
            ST_ENQUEUE: next_state = ST_IDLE;
            default:    next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // fe_id passes through, be_id stamped with the source
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_data       <= be_cp[sel];
            wr_data.valid <= 1'b1;
            wr_data.be_id <= ID_W'(sel);
        end
    end

    assign wr_en = (state == ST_ENQUEUE);

endmodule : cp_ingress

`default_nettype wire

//--- design/cp_egress.sv
`timescale 1ns/100ps
`default_nettype none

module cp_egress
    import nvme_cfg_pkg::*, nvme_msg_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              empty,
    output logic                   rd_en,
    input  cp_msg_t                rd_data,
    output cp_msg_t    [FE_CH-1:0] fe_cp,
    input  wire logic  [FE_CH-1:0] fe_cp_ready
);

    admin_state_t      state;
    admin_state_t      next_state;
    logic [FE_IDX-1:0] target;
    logic              target_ready;

    // --------------------------------------------------
    // route by the low fe_id bits
    // --------------------------------------------------
    assign target       = rd_data.fe_id[FE_IDX-1:0];
    assign target_ready = fe_cp_ready[target];

    // --------------------------------------------------
    // idle / dequeue machine
    // --------------------------------------------------
    always_comb begin
        case (state)
            ST_IDLE:    next_state = empty ? ST_IDLE : ST_DEQUEUE;
            // no fallback channel, wait on the owner
            ST_DEQUEUE: next_state = target_ready ? ST_IDLE : ST_DEQUEUE;
            default:    next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // rd_data is only valid after the fetch, so gate on state
    assign rd_en = (state == ST_IDLE) && !empty;

    always_comb begin
        fe_cp = '0;
        if (state == ST_DEQUEUE && target_ready) begin
            fe_cp[target]       = rd_data;
            fe_cp[target].valid = 1'b1;
        end
    end

endmodule : cp_egress

`default_nettype wire

//--- design/nvme_admin.sv
`timescale 1ns/100ps
`default_nettype none

module nvme_admin
    import nvme_cfg_pkg::*, nvme_msg_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    // front end
    input  rq_msg_t    [FE_CH-1:0] fe_rq,
    output logic       [FE_CH-1:0] fe_rq_ready,
    output cp_msg_t    [FE_CH-1:0] fe_cp,
    input  wire logic  [FE_CH-1:0] fe_cp_ready,
    // back end
    output rq_msg_t    [BE_CH-1:0] be_rq,
    input  wire logic  [BE_CH-1:0] be_rq_ready,
    input  cp_msg_t    [BE_CH-1:0] be_cp,
    output logic       [BE_CH-1:0] be_cp_ready
);

    logic    rq_wr_en;
    rq_msg_t rq_wr_data;
    logic    rq_full;
    logic    rq_rd_en;
    rq_msg_t rq_rd_data;
    logic    rq_empty;

    logic    cp_wr_en;
    cp_msg_t cp_wr_data;
    logic    cp_full;
    logic    cp_rd_en;
    cp_msg_t cp_rd_data;
    logic    cp_empty;

    // --------------------------------------------------
    // request path, front end to back end
    // --------------------------------------------------
    rq_ingress rq_ingress_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fe_rq       (fe_rq),
        .fe_rq_ready (fe_rq_ready),
        .full        (rq_full),
        .wr_en       (rq_wr_en),
        .wr_data     (rq_wr_data)
    );

    admin_fifo #(
        .entry_t (rq_msg_t)
    ) rq_fifo_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (rq_wr_en),
        .wr_data (rq_wr_data),
        .rd_en   (rq_rd_en),
        .rd_data (rq_rd_data),
        .full    (rq_full),
        .empty   (rq_empty)
    );

    rq_egress rq_egress_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .empty       (rq_empty),
        .rd_en       (rq_rd_en),
        .rd_data     (rq_rd_data),
        .be_rq       (be_rq),
        .be_rq_ready (be_rq_ready)
    );

    // --------------------------------------------------
    // completion path, back end to front end
    // --------------------------------------------------
    cp_ingress cp_ingress_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .be_cp       (be_cp),
        .be_cp_ready (be_cp_ready),
        .full        (cp_full),
        .wr_en       (cp_wr_en),
        .wr_data     (cp_wr_data)
    );

    admin_fifo #(
        .entry_t (cp_msg_t)
    ) cp_fifo_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (cp_wr_en),
        .wr_data (cp_wr_data),
        .rd_en   (cp_rd_en),
        .rd_data (cp_rd_data),
        .full    (cp_full),
        .empty   (cp_empty)
    );

    cp_egress cp_egress_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .empty       (cp_empty),
        .rd_en       (cp_rd_en),
        .rd_data     (cp_rd_data),
        .fe_cp       (fe_cp),
        .fe_cp_ready (fe_cp_ready)
    );

endmodule : nvme_admin

`default_nettype wire

//--- test/admin_fifo_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module admin_fifo_assertions (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic wr_en,
    input wire logic rd_en,
    input wire logic full,
    input wire logic empty
);

    // --------------------------------------------------
    // fifo protocol
    // --------------------------------------------------
    // ingress must look at full before writing
    no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(wr_en && full)
    ) else $error("admin_fifo written while full");

    // egress must look at empty before reading
    no_read_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) !(rd_en && empty)
    ) else $error("admin_fifo read while empty");

    // a written entry shows as not empty on the next cycle
    write_leaves_data: assert property (
        @(posedge clk) disable iff (!rst_n) wr_en |=> !empty
    ) else $error("admin_fifo empty after a write");

endmodule : admin_fifo_assertions

bind admin_fifo admin_fifo_assertions admin_fifo_assertions_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (wr_en),
    .rd_en (rd_en),
    .full  (full),
    .empty (empty)
);

`default_nettype wire

//--- test/tb_nvme_admin.sv
`timescale 1ns/100ps
`default_nettype none

module tb_nvme_admin
    import nvme_cfg_pkg::*, nvme_msg_pkg::*;
();

    logic                clk;
    logic                rst_n;
    rq_msg_t [FE_CH-1:0] fe_rq;
    logic    [FE_CH-1:0] fe_rq_ready;
    cp_msg_t [FE_CH-1:0] fe_cp;
    logic    [FE_CH-1:0] fe_cp_ready;
    rq_msg_t [BE_CH-1:0] be_rq;
    logic    [BE_CH-1:0] be_rq_ready;
    cp_msg_t [BE_CH-1:0] be_cp;
    logic    [BE_CH-1:0] be_cp_ready;

    logic [31:0] lfsr_state;
    int          checks;
    int          mismatches;
    int          timeouts;

    // --------------------------------------------------
    // stimulus table
    // --------------------------------------------------
    // path 0 is request, 1 is completion
    // op_fe holds the op for requests, target channel for completions
    // ready is the pattern held on the output side
    typedef struct packed {
        logic       path;
        logic [1:0] src;
        logic [1:0] op_fe;
        logic [3:0] ready;
        logic [1:0] exp_ch;
    } step_t;

    step_t step_table [10] = '{
        '{1'b0, 2'd0, 2'd0, 4'b0001, 2'd0},
        '{1'b0, 2'd1, 2'd1, 4'b0011, 2'd0},
        '{1'b0, 2'd2, 2'd2, 4'b0010, 2'd1},
        '{1'b0, 2'd3, 2'd1, 4'b0011, 2'd0},
        '{1'b1, 2'd0, 2'd0, 4'b1111, 2'd0},
        '{1'b1, 2'd1, 2'd1, 4'b0010, 2'd1},
        '{1'b1, 2'd0, 2'd2, 4'b0100, 2'd2},
        '{1'b1, 2'd1, 2'd3, 4'b1000, 2'd3},
        '{1'b0, 2'd1, 2'd2, 4'b0010, 2'd1},
        '{1'b1, 2'd1, 2'd2, 4'b1110, 2'd2}
    };

    nvme_admin nvme_admin_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fe_rq       (fe_rq),
        .fe_rq_ready (fe_rq_ready),
        .fe_cp       (fe_cp),
        .fe_cp_ready (fe_cp_ready),
        .be_rq       (be_rq),
        .be_rq_ready (be_rq_ready),
        .be_cp       (be_cp),
        .be_cp_ready (be_cp_ready)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            mismatches++;
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timed out waiting for %s", what);
    endtask

    // inputs change 1 ns after the rising edge
    task automatic drive_edge();
        @(posedge clk);
        #1;
    endtask

    // hold valid until ready is seen, drop it after the taking edge
    task automatic send_rq(input int ch, input rq_msg_t msg, input int limit,
                           output bit ok);
        ok = 1'b0;
        drive_edge();
        fe_rq[ch] = msg;
        for (int i = 0; i < limit && !ok; i++) begin
            @(negedge clk);
            ok = fe_rq_ready[ch];
        end
        drive_edge();
        fe_rq[ch] = '0;
    endtask

    task automatic send_cp(input int ch, input cp_msg_t msg, input int limit,
                           output bit ok);
        ok = 1'b0;
        drive_edge();
        be_cp[ch] = msg;
        for (int i = 0; i < limit && !ok; i++) begin
            @(negedge clk);
            ok = be_cp_ready[ch];
        end
        drive_edge();
        be_cp[ch] = '0;
    endtask

    // outputs sampled mid-cycle, exactly one channel may be valid
    task automatic wait_rq_out(input int limit, output int ch, output rq_msg_t msg,
                               output bit ok);
        int hits;
        ok  = 1'b0;
        ch  = 0;
        msg = '0;
        for (int i = 0; i < limit && !ok; i++) begin
            @(negedge clk);
            hits = 0;
            for (int k = 0; k < BE_CH; k++) begin
                if (be_rq[k].valid) begin
                    hits++;
                    ch  = k;
                    msg = be_rq[k];
                end
            end
            if (hits != 0) begin
                ok = 1'b1;
                check_val("be_rq valid count", 64'(1), 64'(hits));
            end
        end
    endtask

    task automatic wait_cp_out(input int limit, output int ch, output cp_msg_t msg,
                               output bit ok);
        int hits;
        ok  = 1'b0;
        ch  = 0;
        msg = '0;
        for (int i = 0; i < limit && !ok; i++) begin
            @(negedge clk);
            hits = 0;
            for (int k = 0; k < FE_CH; k++) begin
                if (fe_cp[k].valid) begin
                    hits++;
                    ch  = k;
                    msg = fe_cp[k];
                end
            end
            if (hits != 0) begin
                ok = 1'b1;
                check_val("fe_cp valid count", 64'(1), 64'(hits));
            end
        end
    endtask

    // --------------------------------------------------
    // test sequences
    // --------------------------------------------------
    task automatic verify_idle();
        logic [FE_CH-1:0] fe_valid;
        logic [BE_CH-1:0] be_valid;
        @(negedge clk);
        for (int k = 0; k < FE_CH; k++) begin
            fe_valid[k] = fe_cp[k].valid;
        end
        for (int k = 0; k < BE_CH; k++) begin
            be_valid[k] = be_rq[k].valid;
        end
        check_val("fe_rq_ready", 64'(0), 64'(fe_rq_ready));
        check_val("be_cp_ready", 64'(0), 64'(be_cp_ready));
        check_val("fe_cp valid", 64'(0), 64'(fe_valid));
        check_val("be_rq valid", 64'(0), 64'(be_valid));
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] addr;
        logic [31:0] hash;
        logic [31:0] id;
        rq_msg_t     rq;
        rq_msg_t     rq_out;
        cp_msg_t     cp;
        cp_msg_t     cp_out;
        int          ch;
        bit          ok;
        take_bits(32, addr);
        take_bits(HASH_W, hash);
        take_bits(ID_W, id);
        drive_edge();
        if (!s.path) begin
            be_rq_ready = s.ready[BE_CH-1:0];
            rq       = '0;
            rq.valid = 1'b1;
            rq.op    = rq_op_t'(s.op_fe);
            rq.addr  = addr;
            rq.hash  = hash[HASH_W-1:0];
            // low bits are random here, ingress must overwrite them
            rq.fe_id = id[ID_W-1:0];
            send_rq(int'(s.src), rq, 32, ok);
            if (!ok) begin
                report_timeout("fe_rq_ready");
            end else begin
                wait_rq_out(64, ch, rq_out, ok);
                if (!ok) begin
                    report_timeout("be_rq valid");
                end else begin
                    check_val("be_rq channel", 64'(s.exp_ch), 64'(ch));
                    check_val("be_rq.op", 64'(s.op_fe), 64'(rq_out.op));
                    check_val("be_rq.addr", 64'(addr), 64'(rq_out.addr));
                    check_val("be_rq.hash", 64'(rq.hash), 64'(rq_out.hash));
                    check_val("be_rq.fe_id", 64'({id[ID_W-1:FE_IDX], s.src}),
                              64'(rq_out.fe_id));
                end
            end
            drive_edge();
            be_rq_ready = '0;
        end else begin
            fe_cp_ready = s.ready;
            cp       = '0;
            cp.valid = 1'b1;
            cp.addr  = addr;
            cp.fe_id = {id[ID_W-1:FE_IDX], s.op_fe};
            // junk be_id, replaced by the source number
            cp.be_id = hash[ID_W-1:0];
            send_cp(int'(s.src), cp, 32, ok);
            if (!ok) begin
                report_timeout("be_cp_ready");
            end else begin
                wait_cp_out(64, ch, cp_out, ok);
                if (!ok) begin
                    report_timeout("fe_cp valid");
                end else begin
                    check_val("fe_cp channel", 64'(s.exp_ch), 64'(ch));
                    check_val("fe_cp.addr", 64'(addr), 64'(cp_out.addr));
                    check_val("fe_cp.fe_id", 64'(cp.fe_id), 64'(cp_out.fe_id));
                    check_val("fe_cp.be_id", 64'(s.src), 64'(cp_out.be_id));
                end
            end
            drive_edge();
            fe_cp_ready = '0;
        end
    endtask

    // channels 1 and 3 valid together, 1 must win
    task automatic priority_test();
        rq_msg_t     first;
        rq_msg_t     second;
        rq_msg_t     out;
        logic [31:0] v;
        int          ch;
        bit          ok;
        first       = '0;
        first.valid = 1'b1;
        first.op    = RQ_WRITE;
        take_bits(32, v);
        first.addr  = v;
        take_bits(ID_W, v);
        first.fe_id = v[ID_W-1:0];
        second      = first;
        second.op   = RQ_TRIM;
        take_bits(32, v);
        second.addr = v;
        drive_edge();
        be_rq_ready = '0;
        fe_rq[3]    = second;
        fe_rq[1]    = first;
        @(negedge clk);
        check_val("fe_rq_ready", 64'(4'b0010), 64'(fe_rq_ready));
        drive_edge();
        fe_rq[1] = '0;
        send_rq(3, second, 32, ok);
        if (!ok) begin
            report_timeout("fe_rq_ready on channel 3");
        end
        drive_edge();
        be_rq_ready = 2'b01;
        wait_rq_out(64, ch, out, ok);
        if (!ok) begin
            report_timeout("first priority delivery");
        end else begin
            check_val("be_rq.addr", 64'(first.addr), 64'(out.addr));
            check_val("be_rq.fe_id", 64'({first.fe_id[ID_W-1:FE_IDX], FE_IDX'(1)}),
                      64'(out.fe_id));
        end
        wait_rq_out(64, ch, out, ok);
        if (!ok) begin
            report_timeout("second priority delivery");
        end else begin
            check_val("be_rq.addr", 64'(second.addr), 64'(out.addr));
            check_val("be_rq.fe_id", 64'({second.fe_id[ID_W-1:FE_IDX], FE_IDX'(3)}),
                      64'(out.fe_id));
        end
        drive_edge();
        be_rq_ready = '0;
    endtask

    // fifo plus the entry parked in egress
    task automatic backpressure_test();
        rq_msg_t     sent [$];
        rq_msg_t     msg;
        rq_msg_t     out;
        logic [31:0] v;
        int          ch;
        int          accepted;
        bit          ok;
        bit          stalled;
        drive_edge();
        be_rq_ready = '0;
        accepted    = 0;
        ok          = 1'b1;
        for (int i = 0; i < FIFO_DEPTH + 2 && ok; i++) begin
            msg       = '0;
            msg.valid = 1'b1;
            msg.op    = RQ_READ;
            take_bits(32, v);
            msg.addr  = v;
            take_bits(ID_W, v);
            msg.fe_id = v[ID_W-1:0];
            send_rq(0, msg, 16, ok);
            if (ok) begin
                accepted++;
                sent.push_back(msg);
            end
        end
        check_val("accepted requests", 64'(FIFO_DEPTH + 1), 64'(accepted));
        drive_edge();
        be_rq_ready = 2'b11;
        stalled     = 1'b0;
        while (sent.size() > 0 && !stalled) begin
            msg = sent.pop_front();
            wait_rq_out(64, ch, out, ok);
            if (!ok) begin
                report_timeout("be_rq after back-pressure");
                stalled = 1'b1;
            end else begin
                check_val("be_rq.addr", 64'(msg.addr), 64'(out.addr));
                check_val("be_rq.fe_id", 64'({msg.fe_id[ID_W-1:FE_IDX], FE_IDX'(0)}),
                          64'(out.fe_id));
            end
        end
        drive_edge();
        be_rq_ready = '0;
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        fe_rq       = '0;
        fe_cp_ready = '0;
        be_rq_ready = '0;
        be_cp       = '0;
        lfsr_state  = 32'h6ff9_5142;
        checks      = 0;
        mismatches  = 0;
        timeouts    = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        verify_idle();
        foreach (step_table[i]) begin
            run_step(step_table[i]);
        end
        priority_test();
        backpressure_test();
        drive_edge();
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // budget scales with the table length
    initial begin
        repeat ($size(step_table) * 64 + 200) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule : tb_nvme_admin

`default_nettype wire

//--- vlog.f
design/nvme_cfg_pkg.sv
design/nvme_msg_pkg.sv
design/admin_fifo.sv
design/rq_ingress.sv
design/rq_egress.sv
design/cp_ingress.sv
design/cp_egress.sv
design/nvme_admin.sv
test/admin_fifo_assertions.sv
test/tb_nvme_admin.sv

//--- run.sh
#!/bin/sh
# build and run the NVMe admin switch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_nvme_admin -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_nvme_admin)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'NO ERRORS'; then
    exit 0
fi
exit 1
